// ==== i3c_loop_top.f ====
rtl/i3c_bus_pkg.sv
rtl/i3c_host_pkg.sv
rtl/i3c_cmd_fifo.sv
rtl/i3c_ctrl_tx.sv
rtl/i3c_bus_harness.sv
rtl/i3c_target_rx.sv
rtl/i3c_loop_top.sv
test/tb_i3c_loop.sv

// ==== rtl/i3c_bus_harness.sv ====
// Simulation-only wired-AND model; every receiver sees the bus two clocks late
`timescale 1ns/1ns
`default_nettype none

module i3c_bus_harness
    import i3c_bus_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,
    input  wire logic [NUM_BUS_DEVICES-1:0] scl_pull_i,
    input  wire logic [NUM_BUS_DEVICES-1:0] sda_pull_i,
    output logic                            scl_o,
    output logic                            sda_o,
    output logic                            scl_sync_o,
    output logic                            sda_sync_o
);

    logic scl_meta;
    logic sda_meta;

    // Released unless any device pulls the line low
    assign scl_o = ~|scl_pull_i;
    assign sda_o = ~|sda_pull_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            scl_meta   <= 1'b1;
            sda_meta   <= 1'b1;
            scl_sync_o <= 1'b1;
            sda_sync_o <= 1'b1;
        end else begin
            scl_meta   <= scl_o;
            sda_meta   <= sda_o;
            scl_sync_o <= scl_meta;
            sda_sync_o <= sda_meta;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i3c_bus_pkg.sv ====
// Bus timing assumes SCL_QUARTER is a power of two; only 7-bit static addressing with write frames
`default_nettype none

package i3c_bus_pkg;

    typedef logic [7:0] i3c_byte_t;

    // Static address answered by the target
    localparam logic [6:0] TARGET_ADDR = 7'h5A;

    // Clock cycles per quarter of one SCL bit
    localparam int unsigned SCL_QUARTER = 4;
    localparam int unsigned SCL_QCNT_W = $clog2(SCL_QUARTER);

    // Controller, target, external device
    localparam int unsigned NUM_BUS_DEVICES = 3;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_BIT,
        TX_ACK,
        TX_STOP,
        TX_RSTART
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ADDR,
        RX_DATA,
        RX_SKIP
    } rx_state_e;

endpackage

`default_nettype wire

// ==== rtl/i3c_cmd_fifo.sv ====
// Push while full and pop while empty are illegal; head is valid whenever empty_o is low
`timescale 1ns/1ns
`default_nettype none

module i3c_cmd_fifo
    import i3c_bus_pkg::*, i3c_host_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire logic      push_i,
    input  wire cmd_op_e   op_i,
    input  wire i3c_byte_t data_i,
    input  wire logic      pop_i,
    output logic           empty_o,
    output logic           full_o,
    output cmd_op_e        op_o,
    output i3c_byte_t      data_o
);

    cmd_op_e   op_mem [CMD_FIFO_DEPTH];
    i3c_byte_t data_mem [CMD_FIFO_DEPTH];

    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_PTR_W:0]   count;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            op_mem[wr_ptr]   <= op_i;
            data_mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty_o = (count == '0);
    assign full_o  = (count == (CMD_PTR_W + 1)'(CMD_FIFO_DEPTH));
    assign op_o    = op_mem[rd_ptr];
    assign data_o  = data_mem[rd_ptr];

    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i |-> !full_o);

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== rtl/i3c_ctrl_tx.sv ====
// Open-drain write-only controller; ext stretching is honoured only while SCL is released
`timescale 1ns/1ns
`default_nettype none

module i3c_ctrl_tx
    import i3c_bus_pkg::*, i3c_host_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire logic      fifo_empty_i,
    input  wire cmd_op_e   fifo_op_i,
    input  wire i3c_byte_t fifo_data_i,
    output logic           fifo_pop_o,
    input  wire logic      scl_sync_i,
    input  wire logic      sda_sync_i,
    output logic           scl_pull_o,
    output logic           sda_pull_o,
    output logic           busy_o,
    output logic           ack_valid_o,
    output logic           nack_o
);

    tx_state_e             state;
    logic [1:0]            phase;
    logic [SCL_QCNT_W-1:0] qcnt;
    logic [2:0]            bit_cnt;
    logic                  frame_open;
    i3c_byte_t             shift_q;
    logic                  hold_high;
    logic                  q_end;

    // High phase waits until SCL really reads high
    assign hold_high = (phase == 2'd2) && !scl_sync_i;
    assign q_end     = (qcnt == SCL_QCNT_W'(SCL_QUARTER - 1)) && !hold_high;

    assign fifo_pop_o = (state == TX_IDLE) && !fifo_empty_i;
    assign busy_o     = (state != TX_IDLE) || frame_open;

    always_ff @(posedge clk_i) begin
        if (reset_i || state == TX_IDLE || hold_high || q_end) begin
            qcnt <= '0;
        end else begin
            qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            shift_q <= fifo_data_i;
        end else if (state == TX_BIT && phase == 2'd3 && q_end) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state       <= TX_IDLE;
            phase       <= '0;
            bit_cnt     <= '0;
            frame_open  <= 1'b0;
            scl_pull_o  <= 1'b0;
            sda_pull_o  <= 1'b0;
            ack_valid_o <= 1'b0;
            nack_o      <= 1'b0;
        end else begin
            ack_valid_o <= 1'b0;
            case (state)
                TX_IDLE: begin
                    phase   <= '0;
                    bit_cnt <= '0;
                    if (fifo_pop_o) begin
                        case (fifo_op_i)
                            OP_ADDR: state <= frame_open ? TX_RSTART : TX_START;
                            OP_DATA: state <= frame_open ? TX_BIT : TX_IDLE;
                            OP_STOP: state <= frame_open ? TX_STOP : TX_IDLE;
                            default: state <= TX_IDLE;
                        endcase
                    end
                end
                TX_START: begin
                    if (q_end && phase == 2'd0) begin
                        sda_pull_o <= 1'b1;
                        phase      <= 2'd1;
                    end else if (q_end) begin
                        scl_pull_o <= 1'b1;
                        frame_open <= 1'b1;
                        phase      <= 2'd0;
                        state      <= TX_BIT;
                    end
                end
                // Bit, ACK, STOP and repeated START share the four-quarter frame
                default: begin
                    if (q_end) begin
                        phase <= phase + 1'b1;
                        case (phase)
                            2'd0: begin
                                if (state == TX_BIT) begin
                                    sda_pull_o <= !shift_q[7];
                                end else begin
                                    sda_pull_o <= (state == TX_STOP);
                                end
                            end
                            2'd1: scl_pull_o <= 1'b0;
                            2'd2: begin
                                if (state == TX_ACK) begin
                                    nack_o <= sda_sync_i;
                                end else if (state == TX_STOP) begin
                                    sda_pull_o <= 1'b0;
                                end else if (state == TX_RSTART) begin
                                    sda_pull_o <= 1'b1;
                                end
                            end
                            default: begin
                                if (state == TX_STOP) begin
                                    frame_open <= 1'b0;
                                    state      <= TX_IDLE;
                                end else begin
                                    scl_pull_o <= 1'b1;
                                end
                                if (state == TX_BIT) begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                    if (bit_cnt == 3'd7) begin
                                        state <= TX_ACK;
                                    end
                                end else if (state == TX_ACK) begin
                                    ack_valid_o <= 1'b1;
                                    state       <= TX_IDLE;
                                end else if (state == TX_RSTART) begin
                                    bit_cnt <= '0;
                                    state   <= TX_BIT;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    a_data_in_frame: assert property (@(posedge clk_i) disable iff (reset_i)
        (fifo_pop_o && fifo_op_i == OP_DATA) |-> frame_open);

endmodule

`default_nettype wire

// ==== rtl/i3c_host_pkg.sv ====
// Command queue depth must be a power of two so the pointers wrap on their own
`default_nettype none

package i3c_host_pkg;

    // OP_ADDR opens a frame, or repeats START when one is open
    typedef enum logic [1:0] {
        OP_ADDR,
        OP_DATA,
        OP_STOP
    } cmd_op_e;

    localparam int unsigned CMD_FIFO_DEPTH = 4;
    localparam int unsigned CMD_PTR_W = $clog2(CMD_FIFO_DEPTH);

endpackage

`default_nettype wire

// ==== rtl/i3c_loop_top.sv ====
// Simulation loop of one controller and one target; ext pulls model a third device on the bus
`timescale 1ns/1ns
`default_nettype none

module i3c_loop_top
    import i3c_bus_pkg::*, i3c_host_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire logic      cmd_push_i,
    input  wire cmd_op_e   cmd_op_i,
    input  wire i3c_byte_t cmd_data_i,
    output logic           cmd_full_o,
    output logic           busy_o,
    output logic           ack_valid_o,
    output logic           nack_o,
    output logic           rx_valid_o,
    output i3c_byte_t      rx_data_o,
    output logic           rx_frame_done_o,
    input  wire logic      scl_ext_pull_i,
    input  wire logic      sda_ext_pull_i,
    output logic           bus_scl_o,
    output logic           bus_sda_o
);

    logic                       fifo_empty;
    logic                       fifo_pop;
    cmd_op_e                    head_op;
    i3c_byte_t                  head_data;
    logic                       ctrl_scl_pull;
    logic                       ctrl_sda_pull;
    logic                       tgt_sda_pull;
    logic                       scl_sync;
    logic                       sda_sync;
    logic [NUM_BUS_DEVICES-1:0] scl_pull;
    logic [NUM_BUS_DEVICES-1:0] sda_pull;

    // Device order is controller, target, external
    assign scl_pull = {scl_ext_pull_i, 1'b0, ctrl_scl_pull};
    assign sda_pull = {sda_ext_pull_i, tgt_sda_pull, ctrl_sda_pull};

    i3c_cmd_fifo u_cmd_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .push_i  (cmd_push_i),
        .op_i    (cmd_op_i),
        .data_i  (cmd_data_i),
        .pop_i   (fifo_pop),
        .empty_o (fifo_empty),
        .full_o  (cmd_full_o),
        .op_o    (head_op),
        .data_o  (head_data)
    );

    i3c_ctrl_tx u_ctrl_tx (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fifo_empty_i (fifo_empty),
        .fifo_op_i    (head_op),
        .fifo_data_i  (head_data),
        .fifo_pop_o   (fifo_pop),
        .scl_sync_i   (scl_sync),
        .sda_sync_i   (sda_sync),
        .scl_pull_o   (ctrl_scl_pull),
        .sda_pull_o   (ctrl_sda_pull),
        .busy_o       (busy_o),
        .ack_valid_o  (ack_valid_o),
        .nack_o       (nack_o)
    );

    i3c_bus_harness u_bus_harness (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .scl_pull_i (scl_pull),
        .sda_pull_i (sda_pull),
        .scl_o      (bus_scl_o),
        .sda_o      (bus_sda_o),
        .scl_sync_o (scl_sync),
        .sda_sync_o (sda_sync)
    );

    i3c_target_rx u_target_rx (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .scl_sync_i      (scl_sync),
        .sda_sync_i      (sda_sync),
        .sda_pull_o      (tgt_sda_pull),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .rx_frame_done_o (rx_frame_done_o)
    );

endmodule

`default_nettype wire

// ==== rtl/i3c_target_rx.sv ====
// Write-only target with a fixed static address; it never stretches SCL
`timescale 1ns/1ns
`default_nettype none

module i3c_target_rx
    import i3c_bus_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic scl_sync_i,
    input  wire logic sda_sync_i,
    output logic      sda_pull_o,
    output logic      rx_valid_o,
    output i3c_byte_t rx_data_o,
    output logic      rx_frame_done_o
);

    rx_state_e  state;
    logic [3:0] bit_cnt;
    logic       addressed;
    logic       scl_q;
    logic       sda_q;
    i3c_byte_t  shift_q;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_det;
    logic       stop_det;
    logic       addr_match;
    logic       ack_now;

    assign scl_rise  = scl_sync_i && !scl_q;
    assign scl_fall  = !scl_sync_i && scl_q;
    // SDA edges while SCL stays high
    assign start_det = scl_sync_i && scl_q && sda_q && !sda_sync_i;
    assign stop_det  = scl_sync_i && scl_q && !sda_q && sda_sync_i;

    assign addr_match = (shift_q == {TARGET_ADDR, 1'b0});
    assign ack_now    = (state == RX_DATA) || (state == RX_ADDR && addr_match);

    always_ff @(posedge clk_i) begin
        if (state != RX_IDLE && scl_rise && bit_cnt < 4'd8) begin
            shift_q <= {shift_q[6:0], sda_sync_i};
        end
        if (scl_rise && bit_cnt == 4'd8) begin
            rx_data_o <= shift_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state           <= RX_IDLE;
            bit_cnt         <= '0;
            addressed       <= 1'b0;
            scl_q           <= 1'b1;
            sda_q           <= 1'b1;
            sda_pull_o      <= 1'b0;
            rx_valid_o      <= 1'b0;
            rx_frame_done_o <= 1'b0;
        end else begin
            scl_q           <= scl_sync_i;
            sda_q           <= sda_sync_i;
            rx_valid_o      <= 1'b0;
            rx_frame_done_o <= 1'b0;
            if (start_det) begin
                state      <= RX_ADDR;
                bit_cnt    <= '0;
                addressed  <= 1'b0;
                sda_pull_o <= 1'b0;
            end else if (stop_det) begin
                rx_frame_done_o <= addressed;
                state           <= RX_IDLE;
                addressed       <= 1'b0;
                sda_pull_o      <= 1'b0;
            end else if (state != RX_IDLE) begin
                if (scl_rise) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    // Ninth rise closes an acknowledged data byte
                    if (bit_cnt == 4'd8 && state == RX_DATA) begin
                        rx_valid_o <= 1'b1;
                    end
                end else if (scl_fall && bit_cnt == 4'd8) begin
                    sda_pull_o <= ack_now;
                    if (state == RX_ADDR && addr_match) begin
                        addressed <= 1'b1;
                    end
                end else if (scl_fall && bit_cnt == 4'd9) begin
                    sda_pull_o <= 1'b0;
                    bit_cnt    <= '0;
                    if (state == RX_ADDR) begin
                        state <= addressed ? RX_DATA : RX_SKIP;
                    end
                end
            end
        end
    end

    a_ack_window: assert property (@(posedge clk_i) disable iff (reset_i)
        sda_pull_o |-> (state != RX_IDLE) && (bit_cnt == 4'd8 || bit_cnt == 4'd9));

    // Controller keeps SCL low whenever the target moves SDA
    a_sda_move_scl_low: assert property (@(posedge clk_i) disable iff (reset_i)
        $changed(sda_pull_o) |-> !scl_sync_i);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_i3c_loop \
    --Mdir obj_dir \
    -o tb_i3c_loop \
    -f i3c_loop_top.f

./obj_dir/tb_i3c_loop

// ==== test/tb_i3c_loop.sv ====
// Self-checking loop test for write frames only; pushes are spaced two cycles so cmd_full_o is current
`timescale 1ns/1ns
`default_nettype none

module tb_i3c_loop
    import i3c_bus_pkg::*, i3c_host_pkg::*;
();

    localparam int unsigned FULL_LIMIT  = 4000;
    localparam int unsigned DRAIN_LIMIT = 40000;

    logic      clk_i;
    logic      reset_i;
    logic      cmd_push_i;
    cmd_op_e   cmd_op_i;
    i3c_byte_t cmd_data_i;
    logic      cmd_full_o;
    logic      busy_o;
    logic      ack_valid_o;
    logic      nack_o;
    logic      rx_valid_o;
    i3c_byte_t rx_data_o;
    logic      rx_frame_done_o;
    logic      scl_ext_pull_i;
    logic      sda_ext_pull_i;
    logic      bus_scl_o;
    logic      bus_sda_o;

    integer      seed = 32'hd283ccfa;
    integer      stretch_seed = 32'hd283ccfa;
    logic        stretch_en;
    i3c_byte_t   exp_bytes[$];
    logic        exp_nacks[$];
    logic        model_open;
    logic        model_match;
    int unsigned exp_frames;
    int unsigned seen_frames = 0;
    int unsigned pushes;

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    i3c_loop_top uut (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .cmd_push_i      (cmd_push_i),
        .cmd_op_i        (cmd_op_i),
        .cmd_data_i      (cmd_data_i),
        .cmd_full_o      (cmd_full_o),
        .busy_o          (busy_o),
        .ack_valid_o     (ack_valid_o),
        .nack_o          (nack_o),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .rx_frame_done_o (rx_frame_done_o),
        .scl_ext_pull_i  (scl_ext_pull_i),
        .sda_ext_pull_i  (sda_ext_pull_i),
        .bus_scl_o       (bus_scl_o),
        .bus_sda_o       (bus_sda_o)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    // Only a write to the static address gets an ACK
    function automatic logic expect_nack(input i3c_byte_t addr_byte);
        return addr_byte != {TARGET_ADDR, 1'b0};
    endfunction

    task automatic check_byte(input i3c_byte_t got);
        i3c_byte_t exp;
        if (exp_bytes.size() == 0) begin
            report_failure("rx_valid_o pulsed although no byte was expected");
        end else begin
            exp = exp_bytes.pop_front();
            if (got !== exp) begin
                report_failure($sformatf("FAIL rx_data_o: got %h expected %h", got, exp));
            end
        end
    endtask

    task automatic check_nack(input logic got);
        logic exp;
        if (exp_nacks.size() == 0) begin
            report_failure("ack_valid_o pulsed although no byte was outstanding");
        end else begin
            exp = exp_nacks.pop_front();
            if (got !== exp) begin
                report_failure($sformatf("FAIL nack_o: got %h expected %h", got, exp));
            end
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_frames();
        if (seen_frames != exp_frames) begin
            report_failure($sformatf("FAIL rx_frame_done_o pulses: got %h expected %h",
                                     seen_frames, exp_frames));
        end
    endtask

    // Expected results follow the order in which commands leave the queue
    task automatic predict_cmd(input cmd_op_e op, input i3c_byte_t data);
        case (op)
            OP_ADDR: begin
                model_open  = 1'b1;
                model_match = !expect_nack(data);
                exp_nacks.push_back(expect_nack(data));
            end
            OP_DATA: begin
                exp_nacks.push_back(!model_match);
                if (model_match) begin
                    exp_bytes.push_back(data);
                end
            end
            default: begin
                if (model_open && model_match) begin
                    exp_frames++;
                end
                model_open  = 1'b0;
                model_match = 1'b0;
            end
        endcase
    endtask

    task automatic push_cmd(input cmd_op_e op, input i3c_byte_t data);
        int unsigned cycles;
        cycles = 0;
        while (cmd_full_o) begin
            if (cycles == FULL_LIMIT) begin
                report_failure("timeout while waiting for cmd_full_o to drop");
            end else begin
                @(posedge clk_i);
                cycles++;
            end
        end
        cmd_push_i <= 1'b1;
        cmd_op_i   <= op;
        cmd_data_i <= data;
        predict_cmd(op, data);
        @(posedge clk_i);
        cmd_push_i <= 1'b0;
        // Full level is registered, so let the push land first
        @(posedge clk_i);
    endtask

    task automatic send_data(input int unsigned nbytes);
        for (int unsigned i = 0; i < nbytes; i++) begin
            push_cmd(OP_DATA, 8'($random(seed)));
        end
    endtask

    function automatic i3c_byte_t random_address();
        if (($random(seed) & 1) != 0) begin
            return {TARGET_ADDR, 1'b0};
        end else begin
            return 8'($random(seed));
        end
    endfunction

    task automatic random_frame();
        push_cmd(OP_ADDR, random_address());
        send_data($random(seed) & 3);
        if (($random(seed) & 3) == 0) begin
            push_cmd(OP_ADDR, random_address());
            send_data($random(seed) & 3);
        end
        push_cmd(OP_STOP, 8'h00);
    endtask

    task automatic wait_drain();
        int unsigned cycles;
        cycles = 0;
        while (busy_o || exp_nacks.size() != 0 || exp_bytes.size() != 0) begin
            if (cycles == DRAIN_LIMIT) begin
                report_failure("timeout while waiting for the commands to complete");
            end else begin
                @(posedge clk_i);
                cycles++;
            end
        end
        check_frames();
    endtask

    // Third device holds SCL low for a while once the controller has pulled it
    initial begin
        int len;
        scl_ext_pull_i <= 1'b0;
        forever begin
            @(posedge clk_i);
            if (stretch_en && !bus_scl_o && (($random(stretch_seed) & 3) == 0)) begin
                len = 1 + ($random(stretch_seed) & 15);
                scl_ext_pull_i <= 1'b1;
                repeat (len) @(posedge clk_i);
                scl_ext_pull_i <= 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk_i);
            if (!reset_i) begin
                if (ack_valid_o) begin
                    check_nack(nack_o);
                end
                if (rx_valid_o) begin
                    check_byte(rx_data_o);
                end
                if (rx_frame_done_o) begin
                    seen_frames++;
                end
            end
        end
    end

    initial begin
        reset_i        <= 1'b1;
        cmd_push_i     <= 1'b0;
        cmd_op_i       <= OP_STOP;
        cmd_data_i     <= 8'h00;
        sda_ext_pull_i <= 1'b0;
        stretch_en     <= 1'b0;
        model_open  = 1'b0;
        model_match = 1'b0;
        exp_frames  = 0;
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);

        check_flag("busy_o", busy_o, 1'b0);
        check_flag("ack_valid_o", ack_valid_o, 1'b0);
        check_flag("rx_valid_o", rx_valid_o, 1'b0);
        check_flag("rx_frame_done_o", rx_frame_done_o, 1'b0);
        check_flag("cmd_full_o", cmd_full_o, 1'b0);
        check_flag("bus_scl_o", bus_scl_o, 1'b1);
        check_flag("bus_sda_o", bus_sda_o, 1'b1);

        // Addressed frame of three bytes
        push_cmd(OP_ADDR, {TARGET_ADDR, 1'b0});
        send_data(3);
        push_cmd(OP_STOP, 8'h00);
        wait_drain();

        // Frame to another target
        push_cmd(OP_ADDR, 8'h3C);
        send_data(2);
        push_cmd(OP_STOP, 8'h00);
        wait_drain();

        // Repeated START away from the target
        push_cmd(OP_ADDR, {TARGET_ADDR, 1'b0});
        send_data(2);
        push_cmd(OP_ADDR, 8'h42);
        send_data(1);
        push_cmd(OP_STOP, 8'h00);
        wait_drain();

        // Fill the queue from idle
        push_cmd(OP_ADDR, {TARGET_ADDR, 1'b0});
        pushes = 1;
        while (!cmd_full_o) begin
            if (pushes > CMD_FIFO_DEPTH) begin
                report_failure("cmd_full_o did not rise within queue depth plus one pushes");
            end else begin
                push_cmd(OP_DATA, 8'($random(seed)));
                pushes++;
            end
        end
        send_data(2);
        push_cmd(OP_STOP, 8'h00);
        wait_drain();

        stretch_en <= 1'b1;
        push_cmd(OP_ADDR, {TARGET_ADDR, 1'b0});
        send_data(4);
        push_cmd(OP_STOP, 8'h00);
        random_frame();
        wait_drain();
        stretch_en <= 1'b0;

        repeat (40) random_frame();
        wait_drain();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
